//--- logic/fe2_pkg.sv
/*
  Shared types for the Fp2 arithmetic unit over p = 2^13 - 1.
  Elements, stream payloads and the partial-product index.
*/
package fe2_pkg;

  localparam int FE_BITS = 13;
  localparam logic [FE_BITS-1:0] FE_P = 13'd8191;
  localparam int TAG_BITS = 8;

  typedef logic [FE_BITS-1:0] fe_t;

  typedef struct packed {
    fe_t re;
    fe_t im;
  } fe2_t;

  // Which partial an Fp beat carries; add and sub only use the first two codes
  typedef enum logic [1:0] {
    M_AA = 2'd0,
    M_BB = 2'd1,
    M_AB = 2'd2,
    M_BA = 2'd3
  } part_e;

  localparam part_e P_RE = M_AA;
  localparam part_e P_IM = M_BB;

  typedef struct packed {
    logic [TAG_BITS-1:0] tag;
    part_e               part;
    logic                src;
  } fe_ctl_t;

  typedef struct packed {
    fe_t     x;
    fe_t     y;
    fe_ctl_t ctl;
  } fe_req_t;

  typedef struct packed {
    fe_t     res;
    fe_ctl_t ctl;
  } fe_rsp_t;

  typedef struct packed {
    fe2_t                a;
    fe2_t                b;
    logic [TAG_BITS-1:0] tag;
  } fe2_req_t;

  typedef struct packed {
    fe2_t                res;
    logic [TAG_BITS-1:0] tag;
  } fe2_rsp_t;

endpackage

//--- logic/fe_mod_mul.sv
/*
  Fp multiplier, three stages: product, Mersenne fold, final correction.
  The whole pipe stalls while its output is held.
*/
`timescale 1ns/1ps

module fe_mod_mul (
  input  logic             i_clk,
  input  logic             i_rst,
  input  fe2_pkg::fe_req_t i_req,
  input  logic             i_valid,
  output logic             o_ready,
  output fe2_pkg::fe_rsp_t o_rsp,
  output logic             o_valid,
  input  logic             i_ready
);
  import fe2_pkg::*;

  logic [2:0]           vld;
  logic [2*FE_BITS-1:0] prod;
  logic [FE_BITS:0]     fold;
  fe_ctl_t              ctl_s1;
  fe_ctl_t              ctl_s2;

  assign o_ready = !o_valid || i_ready;
  assign o_valid = vld[2];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld <= 3'b000;
    end else if (o_ready) begin
      vld <= {vld[1:0], i_valid};
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ready) begin
      prod   <= i_req.x * i_req.y;
      ctl_s1 <= i_req.ctl;
      // 2^13 = 1 mod p, so the high half folds straight onto the low half
      fold   <= {1'b0, prod[2*FE_BITS-1:FE_BITS]} + {1'b0, prod[FE_BITS-1:0]};
      ctl_s2 <= ctl_s1;
      // Fold is below 2p here, one subtraction is enough
      if (fold >= {1'b0, FE_P}) begin
        o_rsp.res <= fe_t'(fold - {1'b0, FE_P});
      end else begin
        o_rsp.res <= fold[FE_BITS-1:0];
      end
      o_rsp.ctl <= ctl_s2;
    end
  end

endmodule

//--- logic/fe_mod_addsub.sv
/*
  Fp adder or subtractor with one output register.
  SUBTRACT picks x - y, otherwise x + y, both fully reduced.
*/
`timescale 1ns/1ps

module fe_mod_addsub #(
  parameter bit SUBTRACT = 1'b0
) (
  input  logic             i_clk,
  input  logic             i_rst,
  input  fe2_pkg::fe_req_t i_req,
  input  logic             i_valid,
  output logic             o_ready,
  output fe2_pkg::fe_rsp_t o_rsp,
  output logic             o_valid,
  input  logic             i_ready
);
  import fe2_pkg::*;

  logic [FE_BITS:0] wide;
  fe_t              res;

  always_comb begin
    if (SUBTRACT) begin
      wide = {1'b0, i_req.x} - {1'b0, i_req.y};
      // Top bit set means the difference went negative
      res = wide[FE_BITS] ? fe_t'(wide + {1'b0, FE_P}) : wide[FE_BITS-1:0];
    end else begin
      wide = {1'b0, i_req.x} + {1'b0, i_req.y};
      res = (wide >= {1'b0, FE_P}) ? fe_t'(wide - {1'b0, FE_P}) : wide[FE_BITS-1:0];
    end
  end

  assign o_ready = !o_valid || i_ready;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid <= 1'b0;
    end else if (o_ready) begin
      o_valid <= i_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (o_ready && i_valid) begin
      o_rsp.res <= res;
      o_rsp.ctl <= i_req.ctl;
    end
  end

endmodule

//--- logic/fe_share_arb.sv
/*
  Two-user round-robin share of one Fp unit.
  The grant index rides in ctl.src and steers each result back.
*/
`timescale 1ns/1ps

module fe_share_arb (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  fe2_pkg::fe_req_t [1:0] i_user_req,
  input  logic [1:0]             i_user_valid,
  output logic [1:0]             o_user_ready,
  output fe2_pkg::fe_req_t       o_res_req,
  output logic                   o_res_valid,
  input  logic                   i_res_ready,
  input  fe2_pkg::fe_rsp_t       i_res_rsp,
  input  logic                   i_res_valid,
  output logic                   o_res_ready,
  output fe2_pkg::fe_rsp_t [1:0] o_user_rsp,
  output logic [1:0]             o_user_valid,
  input  logic [1:0]             i_user_ready
);

  logic ptr;
  logic lock;
  logic lock_sel;
  logic gnt;
  logic ret;

  // A beat that is waiting keeps its grant so the payload stays put
  always_comb begin
    if (lock) begin
      gnt = lock_sel;
    end else if (i_user_valid[ptr]) begin
      gnt = ptr;
    end else begin
      gnt = ~ptr;
    end
    o_res_req         = i_user_req[gnt];
    o_res_req.ctl.src = gnt;
    o_res_valid       = i_user_valid[gnt];
    o_user_ready      = 2'b00;
    o_user_ready[gnt] = i_res_ready;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      ptr      <= 1'b0;
      lock     <= 1'b0;
      lock_sel <= 1'b0;
    end else begin
      // Other user gets priority after a transfer
      if (o_res_valid && i_res_ready) begin
        ptr <= ~gnt;
      end
      lock     <= o_res_valid && !i_res_ready;
      lock_sel <= gnt;
    end
  end

  // Return path
  assign ret         = i_res_rsp.ctl.src;
  assign o_res_ready = i_user_ready[ret];

  always_comb begin
    o_user_rsp        = {2{i_res_rsp}};
    o_user_valid      = 2'b00;
    o_user_valid[ret] = i_res_valid;
  end

endmodule

//--- logic/fe2_arith.sv
/*
  Fp2 sequencer: splits add, sub and mul requests into Fp beats
  and puts the Fp2 results back together, in order per channel.
*/
`timescale 1ns/1ps

module fe2_arith (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_fp_mode,
  // Fp2 channels
  input  fe2_pkg::fe2_req_t i_add_req,
  input  logic              i_add_valid,
  output logic              o_add_ready,
  output fe2_pkg::fe2_rsp_t o_add_rsp,
  output logic              o_add_valid,
  input  logic              i_add_ready,
  input  fe2_pkg::fe2_req_t i_sub_req,
  input  logic              i_sub_valid,
  output logic              o_sub_ready,
  output fe2_pkg::fe2_rsp_t o_sub_rsp,
  output logic              o_sub_valid,
  input  logic              i_sub_ready,
  input  fe2_pkg::fe2_req_t i_mul_req,
  input  logic              i_mul_valid,
  output logic              o_mul_ready,
  output fe2_pkg::fe2_rsp_t o_mul_rsp,
  output logic              o_mul_valid,
  input  logic              i_mul_ready,
  // Fp multiplier
  output fe2_pkg::fe_req_t  o_mul_fe_req,
  output logic              o_mul_fe_valid,
  input  logic              i_mul_fe_ready,
  input  fe2_pkg::fe_rsp_t  i_mul_fe_rsp,
  input  logic              i_mul_fe_valid,
  output logic              o_mul_fe_ready,
  // Adder user 0, add path
  output fe2_pkg::fe_req_t  o_add_fe_req,
  output logic              o_add_fe_valid,
  input  logic              i_add_fe_ready,
  input  fe2_pkg::fe_rsp_t  i_add_fe_rsp,
  input  logic              i_add_fe_valid,
  output logic              o_add_fe_ready,
  // Adder user 1, mul imaginary combine
  output fe2_pkg::fe_req_t  o_mulim_fe_req,
  output logic              o_mulim_fe_valid,
  input  logic              i_mulim_fe_ready,
  input  fe2_pkg::fe_rsp_t  i_mulim_fe_rsp,
  input  logic              i_mulim_fe_valid,
  output logic              o_mulim_fe_ready,
  // Subtractor user 0, sub path
  output fe2_pkg::fe_req_t  o_sub_fe_req,
  output logic              o_sub_fe_valid,
  input  logic              i_sub_fe_ready,
  input  fe2_pkg::fe_rsp_t  i_sub_fe_rsp,
  input  logic              i_sub_fe_valid,
  output logic              o_sub_fe_ready,
  // Subtractor user 1, mul real combine
  output fe2_pkg::fe_req_t  o_mulre_fe_req,
  output logic              o_mulre_fe_valid,
  input  logic              i_mulre_fe_ready,
  input  fe2_pkg::fe_rsp_t  i_mulre_fe_rsp,
  input  logic              i_mulre_fe_valid,
  output logic              o_mulre_fe_ready
);
  import fe2_pkg::*;

  typedef enum logic {ST_RE, ST_IM} pair_state_e;

  logic fp_q;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      fp_q <= 1'b0;
    end else begin
      fp_q <= i_fp_mode;
    end
  end

  // Add and sub share one sequencer shape, index 0 is add and 1 is sub
  logic [1:0] as_valid;
  logic [1:0] as_rready;
  logic [1:0] as_fe_ready;
  logic [1:0] as_fe_rvalid;
  fe2_req_t   as_req [2];
  fe_rsp_t    as_fe_rsp [2];
  logic       as_ready [2];
  logic       as_fe_rready [2];
  fe2_rsp_t   as_rsp [2];
  logic       as_rsp_valid [2];
  fe_req_t    as_fe_req [2];
  logic       as_fe_valid [2];

  assign as_valid     = {i_sub_valid, i_add_valid};
  assign as_rready    = {i_sub_ready, i_add_ready};
  assign as_fe_ready  = {i_sub_fe_ready, i_add_fe_ready};
  assign as_fe_rvalid = {i_sub_fe_valid, i_add_fe_valid};
  assign as_req[0]    = i_add_req;
  assign as_req[1]    = i_sub_req;
  assign as_fe_rsp[0] = i_add_fe_rsp;
  assign as_fe_rsp[1] = i_sub_fe_rsp;

  assign o_add_ready    = as_ready[0];
  assign o_sub_ready    = as_ready[1];
  assign o_add_rsp      = as_rsp[0];
  assign o_sub_rsp      = as_rsp[1];
  assign o_add_valid    = as_rsp_valid[0];
  assign o_sub_valid    = as_rsp_valid[1];
  assign o_add_fe_req   = as_fe_req[0];
  assign o_sub_fe_req   = as_fe_req[1];
  assign o_add_fe_valid = as_fe_valid[0];
  assign o_sub_fe_valid = as_fe_valid[1];
  assign o_add_fe_ready = as_fe_rready[0];
  assign o_sub_fe_ready = as_fe_rready[1];

  for (genvar c = 0; c < 2; c++) begin : g_pair
    pair_state_e st;
    logic        fe_free;
    logic        out_free;

    assign fe_free         = !as_fe_valid[c] || as_fe_ready[c];
    assign out_free        = !as_rsp_valid[c] || as_rready[c];
    // Request is taken with its last Fp beat
    assign as_ready[c]     = (fp_q || st == ST_IM) && fe_free;
    assign as_fe_rready[c] = out_free;

    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        st             <= ST_RE;
        as_fe_valid[c] <= 1'b0;
      end else if (fe_free) begin
        as_fe_valid[c] <= as_valid[c];
        if (as_valid[c] && !fp_q) begin
          st <= (st == ST_RE) ? ST_IM : ST_RE;
        end
      end
    end

    always_ff @(posedge i_clk) begin
      if (fe_free) begin
        as_fe_req[c].x   <= (st == ST_RE) ? as_req[c].a.re : as_req[c].a.im;
        as_fe_req[c].y   <= (st == ST_RE) ? as_req[c].b.re : as_req[c].b.im;
        as_fe_req[c].ctl <= '{tag: as_req[c].tag, part: (st == ST_RE) ? P_RE : P_IM,
                               src: 1'b0};
      end
    end

    // Real part waits in the output register for the imaginary one
    always_ff @(posedge i_clk) begin
      if (i_rst) begin
        as_rsp_valid[c] <= 1'b0;
      end else if (out_free) begin
        as_rsp_valid[c] <= as_fe_rvalid[c] && (fp_q || as_fe_rsp[c].ctl.part == P_IM);
      end
    end

    always_ff @(posedge i_clk) begin
      if (out_free && as_fe_rvalid[c]) begin
        as_rsp[c].tag <= as_fe_rsp[c].ctl.tag;
        if (as_fe_rsp[c].ctl.part == P_IM) begin
          as_rsp[c].res.im <= as_fe_rsp[c].res;
        end else begin
          as_rsp[c].res.re <= as_fe_rsp[c].res;
          if (fp_q) begin
            as_rsp[c].res.im <= '0;
          end
        end
      end
    end
  end

  // (a + bi)(a' + b'i) = (aa' - bb') + (ab' + a'b)i
  part_e      mul_st;
  logic       mul_fe_free;
  logic       mul_take;
  logic       mul_is_re;
  logic       re_free;
  logic       im_free;
  logic [1:0] got;

  assign mul_fe_free = !o_mul_fe_valid || i_mul_fe_ready;
  assign o_mul_ready = (fp_q || mul_st == M_BA) && mul_fe_free;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mul_st         <= M_AA;
      o_mul_fe_valid <= 1'b0;
    end else if (mul_fe_free) begin
      o_mul_fe_valid <= i_mul_valid;
      if (i_mul_valid && !fp_q) begin
        mul_st <= part_e'(mul_st + 2'd1);
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (mul_fe_free) begin
      o_mul_fe_req.ctl <= '{tag: i_mul_req.tag, part: mul_st, src: 1'b0};
      case (mul_st)
        M_AA: begin
          o_mul_fe_req.x <= i_mul_req.a.re;
          o_mul_fe_req.y <= i_mul_req.b.re;
        end
        M_BB: begin
          o_mul_fe_req.x <= i_mul_req.a.im;
          o_mul_fe_req.y <= i_mul_req.b.im;
        end
        M_AB: begin
          o_mul_fe_req.x <= i_mul_req.a.re;
          o_mul_fe_req.y <= i_mul_req.b.im;
        end
        default: begin
          o_mul_fe_req.x <= i_mul_req.b.re;
          o_mul_fe_req.y <= i_mul_req.a.im;
        end
      endcase
    end
  end

  // Products pair up into one subtractor beat and one adder beat
  assign mul_take  = o_mul_valid && i_mul_ready;
  assign re_free   = !o_mulre_fe_valid || i_mulre_fe_ready;
  assign im_free   = !o_mulim_fe_valid || i_mulim_fe_ready;
  assign mul_is_re = (i_mul_fe_rsp.ctl.part == M_AA) || (i_mul_fe_rsp.ctl.part == M_BB);

  always_comb begin
    if (fp_q) begin
      o_mul_fe_ready = !got[0] || mul_take;
    end else begin
      o_mul_fe_ready = mul_is_re ? re_free : im_free;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mulre_fe_valid <= 1'b0;
      o_mulim_fe_valid <= 1'b0;
    end else begin
      if (re_free) begin
        o_mulre_fe_valid <= i_mul_fe_valid && !fp_q && i_mul_fe_rsp.ctl.part == M_BB;
      end
      if (im_free) begin
        o_mulim_fe_valid <= i_mul_fe_valid && !fp_q && i_mul_fe_rsp.ctl.part == M_BA;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_mul_fe_valid && o_mul_fe_ready) begin
      case (i_mul_fe_rsp.ctl.part)
        M_AA: o_mulre_fe_req.x <= i_mul_fe_rsp.res;
        M_BB: begin
          o_mulre_fe_req.y   <= i_mul_fe_rsp.res;
          o_mulre_fe_req.ctl <= i_mul_fe_rsp.ctl;
        end
        M_AB: o_mulim_fe_req.x <= i_mul_fe_rsp.res;
        default: begin
          o_mulim_fe_req.y   <= i_mul_fe_rsp.res;
          o_mulim_fe_req.ctl <= i_mul_fe_rsp.ctl;
        end
      endcase
    end
  end

  // Bit 1 real combine, bit 0 imaginary combine
  assign o_mul_valid      = &got;
  assign o_mulre_fe_ready = !got[1] || mul_take;
  assign o_mulim_fe_ready = !got[0] || mul_take;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      got <= 2'b00;
    end else if (fp_q) begin
      if (!got[0] || mul_take) begin
        got <= {2{i_mul_fe_valid}};
      end
    end else begin
      if (o_mulre_fe_ready) begin
        got[1] <= i_mulre_fe_valid;
      end
      if (o_mulim_fe_ready) begin
        got[0] <= i_mulim_fe_valid;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (fp_q) begin
      if (o_mul_fe_ready && i_mul_fe_valid) begin
        o_mul_rsp.res <= '{re: i_mul_fe_rsp.res, im: '0};
        o_mul_rsp.tag <= i_mul_fe_rsp.ctl.tag;
      end
    end else begin
      if (o_mulre_fe_ready && i_mulre_fe_valid) begin
        o_mul_rsp.res.re <= i_mulre_fe_rsp.res;
        o_mul_rsp.tag    <= i_mulre_fe_rsp.ctl.tag;
      end
      if (o_mulim_fe_ready && i_mulim_fe_valid) begin
        o_mul_rsp.res.im <= i_mulim_fe_rsp.res;
      end
    end
  end

endmodule

//--- logic/fe2_alu_top.sv
/*
  Fp2 ALU top: sequencer, Fp multiplier, shared adder and subtractor.
*/
`timescale 1ns/1ps

module fe2_alu_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_fp_mode,
  input  fe2_pkg::fe2_req_t i_add_req,
  input  logic              i_add_valid,
  output logic              o_add_ready,
  output fe2_pkg::fe2_rsp_t o_add_rsp,
  output logic              o_add_valid,
  input  logic              i_add_ready,
  input  fe2_pkg::fe2_req_t i_sub_req,
  input  logic              i_sub_valid,
  output logic              o_sub_ready,
  output fe2_pkg::fe2_rsp_t o_sub_rsp,
  output logic              o_sub_valid,
  input  logic              i_sub_ready,
  input  fe2_pkg::fe2_req_t i_mul_req,
  input  logic              i_mul_valid,
  output logic              o_mul_ready,
  output fe2_pkg::fe2_rsp_t o_mul_rsp,
  output logic              o_mul_valid,
  input  logic              i_mul_ready
);
  import fe2_pkg::*;

  // Multiplier stream
  fe_req_t mul_req;
  logic    mul_req_valid;
  logic    mul_req_ready;
  fe_rsp_t mul_rsp;
  logic    mul_rsp_valid;
  logic    mul_rsp_ready;

  // Arbiter user side, user 0 is the plain path and user 1 the mul combine
  fe_req_t [1:0] add_user_req;
  logic [1:0]    add_user_valid;
  logic [1:0]    add_user_ready;
  fe_rsp_t [1:0] add_user_rsp;
  logic [1:0]    add_user_rsp_valid;
  logic [1:0]    add_user_rsp_ready;
  fe_req_t [1:0] sub_user_req;
  logic [1:0]    sub_user_valid;
  logic [1:0]    sub_user_ready;
  fe_rsp_t [1:0] sub_user_rsp;
  logic [1:0]    sub_user_rsp_valid;
  logic [1:0]    sub_user_rsp_ready;

  // Shared unit side
  fe_req_t add_req;
  logic    add_req_valid;
  logic    add_req_ready;
  fe_rsp_t add_rsp;
  logic    add_rsp_valid;
  logic    add_rsp_ready;
  fe_req_t sub_req;
  logic    sub_req_valid;
  logic    sub_req_ready;
  fe_rsp_t sub_rsp;
  logic    sub_rsp_valid;
  logic    sub_rsp_ready;

  fe2_arith fe2_arith_inst (
    .i_clk            (i_clk),
    .i_rst            (i_rst),
    .i_fp_mode        (i_fp_mode),
    .i_add_req        (i_add_req),
    .i_add_valid      (i_add_valid),
    .o_add_ready      (o_add_ready),
    .o_add_rsp        (o_add_rsp),
    .o_add_valid      (o_add_valid),
    .i_add_ready      (i_add_ready),
    .i_sub_req        (i_sub_req),
    .i_sub_valid      (i_sub_valid),
    .o_sub_ready      (o_sub_ready),
    .o_sub_rsp        (o_sub_rsp),
    .o_sub_valid      (o_sub_valid),
    .i_sub_ready      (i_sub_ready),
    .i_mul_req        (i_mul_req),
    .i_mul_valid      (i_mul_valid),
    .o_mul_ready      (o_mul_ready),
    .o_mul_rsp        (o_mul_rsp),
    .o_mul_valid      (o_mul_valid),
    .i_mul_ready      (i_mul_ready),
    .o_mul_fe_req     (mul_req),
    .o_mul_fe_valid   (mul_req_valid),
    .i_mul_fe_ready   (mul_req_ready),
    .i_mul_fe_rsp     (mul_rsp),
    .i_mul_fe_valid   (mul_rsp_valid),
    .o_mul_fe_ready   (mul_rsp_ready),
    .o_add_fe_req     (add_user_req[0]),
    .o_add_fe_valid   (add_user_valid[0]),
    .i_add_fe_ready   (add_user_ready[0]),
    .i_add_fe_rsp     (add_user_rsp[0]),
    .i_add_fe_valid   (add_user_rsp_valid[0]),
    .o_add_fe_ready   (add_user_rsp_ready[0]),
    .o_mulim_fe_req   (add_user_req[1]),
    .o_mulim_fe_valid (add_user_valid[1]),
    .i_mulim_fe_ready (add_user_ready[1]),
    .i_mulim_fe_rsp   (add_user_rsp[1]),
    .i_mulim_fe_valid (add_user_rsp_valid[1]),
    .o_mulim_fe_ready (add_user_rsp_ready[1]),
    .o_sub_fe_req     (sub_user_req[0]),
    .o_sub_fe_valid   (sub_user_valid[0]),
    .i_sub_fe_ready   (sub_user_ready[0]),
    .i_sub_fe_rsp     (sub_user_rsp[0]),
    .i_sub_fe_valid   (sub_user_rsp_valid[0]),
    .o_sub_fe_ready   (sub_user_rsp_ready[0]),
    .o_mulre_fe_req   (sub_user_req[1]),
    .o_mulre_fe_valid (sub_user_valid[1]),
    .i_mulre_fe_ready (sub_user_ready[1]),
    .i_mulre_fe_rsp   (sub_user_rsp[1]),
    .i_mulre_fe_valid (sub_user_rsp_valid[1]),
    .o_mulre_fe_ready (sub_user_rsp_ready[1])
  );

  fe_mod_mul fe_mod_mul_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (mul_req),
    .i_valid (mul_req_valid),
    .o_ready (mul_req_ready),
    .o_rsp   (mul_rsp),
    .o_valid (mul_rsp_valid),
    .i_ready (mul_rsp_ready)
  );

  fe_share_arb add_arb_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_user_req   (add_user_req),
    .i_user_valid (add_user_valid),
    .o_user_ready (add_user_ready),
    .o_res_req    (add_req),
    .o_res_valid  (add_req_valid),
    .i_res_ready  (add_req_ready),
    .i_res_rsp    (add_rsp),
    .i_res_valid  (add_rsp_valid),
    .o_res_ready  (add_rsp_ready),
    .o_user_rsp   (add_user_rsp),
    .o_user_valid (add_user_rsp_valid),
    .i_user_ready (add_user_rsp_ready)
  );

  fe_mod_addsub #(.SUBTRACT(1'b0)) fe_add_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (add_req),
    .i_valid (add_req_valid),
    .o_ready (add_req_ready),
    .o_rsp   (add_rsp),
    .o_valid (add_rsp_valid),
    .i_ready (add_rsp_ready)
  );

  fe_share_arb sub_arb_inst (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_user_req   (sub_user_req),
    .i_user_valid (sub_user_valid),
    .o_user_ready (sub_user_ready),
    .o_res_req    (sub_req),
    .o_res_valid  (sub_req_valid),
    .i_res_ready  (sub_req_ready),
    .i_res_rsp    (sub_rsp),
    .i_res_valid  (sub_rsp_valid),
    .o_res_ready  (sub_rsp_ready),
    .o_user_rsp   (sub_user_rsp),
    .o_user_valid (sub_user_rsp_valid),
    .i_user_ready (sub_user_rsp_ready)
  );

  fe_mod_addsub #(.SUBTRACT(1'b1)) fe_sub_inst (
    .i_clk   (i_clk),
    .i_rst   (i_rst),
    .i_req   (sub_req),
    .i_valid (sub_req_valid),
    .o_ready (sub_req_ready),
    .o_rsp   (sub_rsp),
    .o_valid (sub_rsp_valid),
    .i_ready (sub_rsp_ready)
  );

endmodule

//--- test/fe2_alu_clkgen.sv
/*
  Free-running testbench clock with a 4 ns period.
*/
`timescale 1ns/1ps

module fe2_alu_clkgen (
  output logic o_clk
);

  localparam real HALF_NS = 2.0;

  initial begin
    o_clk = 1'b0;
    forever begin
      #(HALF_NS) o_clk = ~o_clk;
    end
  end

endmodule

//--- test/fe2_alu_assertions.sv
/*
  Stream protocol checks bound into the Fp2 sequencer.
  Reset values, payload hold under back-pressure, reduced products.
*/
`timescale 1ns/1ps

module fe2_alu_assertions (
  input logic              i_clk,
  input logic              i_rst,
  input fe2_pkg::fe2_rsp_t i_add_rsp,
  input logic              i_add_valid,
  input logic              i_add_ready,
  input fe2_pkg::fe2_rsp_t i_sub_rsp,
  input logic              i_sub_valid,
  input logic              i_sub_ready,
  input fe2_pkg::fe2_rsp_t i_mul_rsp,
  input logic              i_mul_valid,
  input logic              i_mul_ready,
  input fe2_pkg::fe_req_t  i_mul_fe_req,
  input logic              i_mul_fe_req_valid,
  input logic              i_mul_fe_req_ready,
  input fe2_pkg::fe_rsp_t  i_mul_fe_rsp,
  input logic              i_mul_fe_rsp_valid
);
  import fe2_pkg::*;

  int fail_count = 0;

  // Synchronous reset clears every valid by the next edge
  reset_clears_valid: assert property (@(posedge i_clk)
    i_rst |=> !(i_add_valid || i_sub_valid || i_mul_valid ||
                i_mul_fe_req_valid || i_mul_fe_rsp_valid))
  else begin
    $error("A valid output is high after a reset edge");
    fail_count++;
  end

  add_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_add_valid && !i_add_ready |=> i_add_valid && $stable(i_add_rsp))
  else begin
    $error("Add response changed or dropped while stalled");
    fail_count++;
  end

  sub_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_sub_valid && !i_sub_ready |=> i_sub_valid && $stable(i_sub_rsp))
  else begin
    $error("Sub response changed or dropped while stalled");
    fail_count++;
  end

  mul_rsp_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_valid && !i_mul_ready |=> i_mul_valid && $stable(i_mul_rsp))
  else begin
    $error("Mul response changed or dropped while stalled");
    fail_count++;
  end

  mul_fe_req_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_fe_req_valid && !i_mul_fe_req_ready |=>
      i_mul_fe_req_valid && $stable(i_mul_fe_req))
  else begin
    $error("Multiplier request changed or dropped while stalled");
    fail_count++;
  end

  // Multiplier results must be fully reduced
  mul_fe_reduced: assert property (@(posedge i_clk) disable iff (i_rst)
    i_mul_fe_rsp_valid |-> i_mul_fe_rsp.res < FE_P)
  else begin
    $error("Multiplier result is not below the modulus");
    fail_count++;
  end

endmodule

//--- test/fe2_alu_tb.sv
/*
  Testbench for the Fp2 ALU: random add, sub and mul traffic checked
  against a field model, with mixed back-pressure and Fp mode phases.
*/
`timescale 1ns/1ps

module fe2_alu_tb;
  import fe2_pkg::*;

  localparam int MOD         = 8191;
  localparam int N_SINGLE    = 150;
  localparam int N_MIXED     = 100;
  localparam int N_FP        = 100;
  localparam int TOTAL_OPS   = 3 * N_SINGLE + 3 * N_MIXED + 3 * N_FP;
  localparam int CYCLE_LIMIT = 40 * TOTAL_OPS + 1000;
  localparam logic [31:0] SEED = 32'haca8135c;

  logic           i_clk;
  logic           i_rst;
  logic           fp_mode;
  // Channel index 0 is add, 1 is sub, 2 is mul
  fe2_req_t [2:0] req;
  logic [2:0]     req_valid;
  logic [2:0]     req_ready;
  fe2_rsp_t [2:0] rsp;
  logic [2:0]     rsp_valid;
  logic [2:0]     rsp_ready;

  fe2_rsp_t   exp_add_q [$];
  fe2_rsp_t   exp_sub_q [$];
  fe2_rsp_t   exp_mul_q [$];
  int         to_send [3];
  logic [2:0] taken;
  int         cycles;

  fe2_alu_clkgen clkgen_inst (
    .o_clk (i_clk)
  );

  fe2_alu_top fe2_alu_top_inst (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_fp_mode   (fp_mode),
    .i_add_req   (req[0]),
    .i_add_valid (req_valid[0]),
    .o_add_ready (req_ready[0]),
    .o_add_rsp   (rsp[0]),
    .o_add_valid (rsp_valid[0]),
    .i_add_ready (rsp_ready[0]),
    .i_sub_req   (req[1]),
    .i_sub_valid (req_valid[1]),
    .o_sub_ready (req_ready[1]),
    .o_sub_rsp   (rsp[1]),
    .o_sub_valid (rsp_valid[1]),
    .i_sub_ready (rsp_ready[1]),
    .i_mul_req   (req[2]),
    .i_mul_valid (req_valid[2]),
    .o_mul_ready (req_ready[2]),
    .o_mul_rsp   (rsp[2]),
    .o_mul_valid (rsp_valid[2]),
    .i_mul_ready (rsp_ready[2])
  );

  bind fe2_arith fe2_alu_assertions fe2_alu_assertions_inst (
    .i_clk              (i_clk),
    .i_rst              (i_rst),
    .i_add_rsp          (o_add_rsp),
    .i_add_valid        (o_add_valid),
    .i_add_ready        (i_add_ready),
    .i_sub_rsp          (o_sub_rsp),
    .i_sub_valid        (o_sub_valid),
    .i_sub_ready        (i_sub_ready),
    .i_mul_rsp          (o_mul_rsp),
    .i_mul_valid        (o_mul_valid),
    .i_mul_ready        (i_mul_ready),
    .i_mul_fe_req       (o_mul_fe_req),
    .i_mul_fe_req_valid (o_mul_fe_valid),
    .i_mul_fe_req_ready (i_mul_fe_ready),
    .i_mul_fe_rsp       (i_mul_fe_rsp),
    .i_mul_fe_rsp_valid (i_mul_fe_valid)
  );

  task automatic stop_on_error();
    $display("Finished with errors");
    $fatal(1, "Run stopped at the first error");
  endtask

  function automatic int protocol_errors();
    return fe2_alu_top_inst.fe2_arith_inst.fe2_alu_assertions_inst.fail_count;
  endfunction

  function automatic string rsp_name(int ch);
    case (ch)
      0: return "o_add_rsp";
      1: return "o_sub_rsp";
      default: return "o_mul_rsp";
    endcase
  endfunction

  // Mostly uniform, with the corner values 0, 1 and p - 1 mixed in
  function automatic fe_t rand_fe();
    int pick;
    pick = $urandom_range(15, 0);
    case (pick)
      0: return fe_t'(0);
      1: return fe_t'(1);
      2: return fe_t'(MOD - 1);
      default: return fe_t'($urandom_range(MOD - 1, 0));
    endcase
  endfunction

  // Field model with i^2 = -1 and only the real parts in Fp mode
  function automatic fe2_rsp_t model_rsp(int ch, fe2_req_t r, logic fpm);
    int       ar;
    int       ai;
    int       br;
    int       bi;
    int       re;
    int       im;
    fe2_rsp_t e;
    ar = r.a.re;
    ai = fpm ? 0 : int'(r.a.im);
    br = r.b.re;
    bi = fpm ? 0 : int'(r.b.im);
    case (ch)
      0: begin
        re = (ar + br) % MOD;
        im = (ai + bi) % MOD;
      end
      1: begin
        re = (ar - br + MOD) % MOD;
        im = (ai - bi + MOD) % MOD;
      end
      default: begin
        re = ((ar * br - ai * bi) % MOD + MOD) % MOD;
        im = (ar * bi + ai * br) % MOD;
      end
    endcase
    e.res.re = fe_t'(re);
    e.res.im = fe_t'(im);
    e.tag    = r.tag;
    return e;
  endfunction

  function automatic int queue_depth(int ch);
    case (ch)
      0: return exp_add_q.size();
      1: return exp_sub_q.size();
      default: return exp_mul_q.size();
    endcase
  endfunction

  task automatic push_expected(int ch, fe2_rsp_t e);
    case (ch)
      0: exp_add_q.push_back(e);
      1: exp_sub_q.push_back(e);
      default: exp_mul_q.push_back(e);
    endcase
  endtask

  task automatic check_response(int ch);
    fe2_rsp_t e;
    fe2_rsp_t got;
    got = rsp[ch];
    assert (queue_depth(ch) > 0) else begin
      $display("Response on %s arrived with no request outstanding", rsp_name(ch));
      stop_on_error();
    end
    case (ch)
      0: e = exp_add_q.pop_front();
      1: e = exp_sub_q.pop_front();
      default: e = exp_mul_q.pop_front();
    endcase
    assert (got === e) else begin
      $display("MISMATCH %s got re=0x%h im=0x%h tag=0x%h expected re=0x%h im=0x%h tag=0x%h",
               rsp_name(ch), got.res.re, got.res.im, got.tag,
               e.res.re, e.res.im, e.tag);
      stop_on_error();
    end
  endtask

  // Called on the falling edge; a request stays put until it is taken
  task automatic drive_inputs(int vpct, int rpct);
    for (int ch = 0; ch < 3; ch++) begin
      if (!req_valid[ch] || taken[ch]) begin
        if (to_send[ch] > 0 && $urandom_range(99, 0) < vpct) begin
          req[ch].a.re  = rand_fe();
          req[ch].a.im  = rand_fe();
          req[ch].b.re  = rand_fe();
          req[ch].b.im  = rand_fe();
          req[ch].tag   = TAG_BITS'($urandom_range(255, 0));
          req_valid[ch] = 1'b1;
          to_send[ch]--;
        end else begin
          req_valid[ch] = 1'b0;
        end
      end
      rsp_ready[ch] = ($urandom_range(99, 0) < rpct);
    end
    taken = '0;
  endtask

  task automatic sample_outputs();
    for (int ch = 0; ch < 3; ch++) begin
      if (req_valid[ch] && req_ready[ch]) begin
        push_expected(ch, model_rsp(ch, req[ch], fp_mode));
        taken[ch] = 1'b1;
      end
      if (rsp_valid[ch] && rsp_ready[ch]) begin
        check_response(ch);
      end
    end
    assert (protocol_errors() == 0) else begin
      $display("A stream protocol assertion failed inside the DUT");
      stop_on_error();
    end
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, responses stopped arriving", cycles);
      stop_on_error();
    end
  endtask

  function automatic bit phase_done();
    int left;
    left = to_send[0] + to_send[1] + to_send[2];
    left += queue_depth(0) + queue_depth(1) + queue_depth(2);
    return (left == 0) && ((req_valid & ~taken) == 3'b000);
  endfunction

  task automatic run_phase(int n_add, int n_sub, int n_mul, int vpct, int rpct);
    to_send[0] = n_add;
    to_send[1] = n_sub;
    to_send[2] = n_mul;
    do begin
      @(negedge i_clk);
      drive_inputs(vpct, rpct);
      @(posedge i_clk);
      sample_outputs();
    end while (!phase_done());
    @(negedge i_clk);
    req_valid = '0;
    rsp_ready = '1;
    taken     = '0;
  endtask

  initial begin
    i_rst     = 1'b1;
    fp_mode   = 1'b0;
    req       = '0;
    req_valid = '0;
    rsp_ready = '0;
    taken     = '0;
    cycles    = 0;
    void'($urandom(SEED));

    // Response valids low during reset and on the first cycle after it
    repeat (8) begin
      @(posedge i_clk);
      @(negedge i_clk);
      assert (rsp_valid === 3'b000) else begin
        $display("A response valid is high during reset");
        stop_on_error();
      end
    end
    i_rst = 1'b0;
    @(posedge i_clk);
    @(negedge i_clk);
    assert (rsp_valid === 3'b000) else begin
      $display("A response valid is high on the first cycle after reset");
      stop_on_error();
    end

    // One channel at a time at full rate
    run_phase(N_SINGLE, 0, 0, 100, 100);
    run_phase(0, N_SINGLE, 0, 100, 100);
    run_phase(0, 0, N_SINGLE, 100, 100);

    // All channels together with random valid and ready
    run_phase(N_MIXED, N_MIXED, N_MIXED, 60, 50);

    // Mode switch while idle, then plain Fp traffic
    fp_mode = 1'b1;
    repeat (2) @(negedge i_clk);
    run_phase(N_FP, N_FP, N_FP, 70, 70);

    if (protocol_errors() == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      $display("Finished with errors");
      $fatal(1, "Protocol assertions failed during the run");
    end
  end

endmodule

//--- all.f
logic/fe2_pkg.sv
logic/fe_mod_mul.sv
logic/fe_mod_addsub.sv
logic/fe_share_arb.sv
logic/fe2_arith.sv
logic/fe2_alu_top.sv
test/fe2_alu_clkgen.sv
test/fe2_alu_assertions.sv
test/fe2_alu_tb.sv
